/* common/cpu16_pkg.sv */
`default_nettype none

package cpu16_pkg;

  // datapath widths
  localparam int data_width    = 16;  // registers, data bus and address
  localparam int reg_count     = 8;
  localparam int reg_sel_width = 3;

  // register roles
  localparam logic [reg_sel_width-1:0] sp_index = 3'd6;  // stack pointer
  localparam logic [reg_sel_width-1:0] ip_index = 3'd7;  // instruction pointer

  // first fetch address after reset
  localparam logic [data_width-1:0] ip_reset_value = 16'h8000;

  // memory map: top address bit picks the program rom
  localparam int rom_base_bit   = 15;
  localparam int rom_depth      = 256;
  localparam int rom_addr_width = 8;

  // alu operations, bit 2 marks the ones that update carry
  typedef enum logic [3:0] {
    op_zero   = 4'h0,
    op_load_a = 4'h1,
    op_inc    = 4'h2,
    op_dec    = 4'h3,
    op_asl    = 4'h4,
    op_lsr    = 4'h5,
    op_rol    = 4'h6,
    op_ror    = 4'h7,
    op_or     = 4'h8,
    op_and    = 4'h9,
    op_xor    = 4'ha,
    op_load_b = 4'hb,
    op_add    = 4'hc,
    op_sub    = 4'hd,
    op_adc    = 4'he,
    op_sbb    = 4'hf
  } alu_op_t;

  // core sequencer states
  typedef enum logic [2:0] {
    st_reset        = 3'd0,
    st_select       = 3'd1,  // fetch address out
    st_decode       = 3'd2,  // instruction word on data_in
    st_compute      = 3'd3,  // alu result to rdest
    st_decode_wait  = 3'd4,
    st_compute_wait = 3'd5
  } cpu_state_t;

endpackage

`default_nettype wire

/* cpu16/cpu16_alu.sv */
`default_nettype none

module cpu16_alu #(
  parameter int width = cpu16_pkg::data_width
) (
  input  logic [width-1:0]   a,
  input  logic [width-1:0]   b,
  input  logic               carry_in,
  input  cpu16_pkg::alu_op_t op,
  output logic [width:0]     y         // result, carry in top bit
);

  import cpu16_pkg::*;

  logic [width:0] a_ext;
  logic [width:0] b_ext;
  logic [width:0] cin_ext;
  logic [width:0] one;

  // zero extended operands, so borrow lands in the top bit too
  assign a_ext   = {1'b0, a};
  assign b_ext   = {1'b0, b};
  assign cin_ext = {{width{1'b0}}, carry_in};
  assign one     = {{width{1'b0}}, 1'b1};

  always_comb begin
    y = '0;
    case (op)
      // unary
      op_zero:   y = '0;
      op_load_a: y = a_ext;
      op_inc:    y = a_ext + one;
      op_dec:    y = a_ext - one;

      // shifts, bit shifted out goes to the carry position
      op_asl:    y = {a, 1'b0};
      op_lsr:    y = {a[0], 1'b0, a[width-1:1]};
      op_rol:    y = {a, carry_in};
      op_ror:    y = {a[0], carry_in, a[width-1:1]};

      // logic ops and loads leave carry bit clear
      op_or:     y = {1'b0, a | b};
      op_and:    y = {1'b0, a & b};
      op_xor:    y = {1'b0, a ^ b};
      op_load_b: y = b_ext;

      // arithmetic
      op_add:    y = a_ext + b_ext;
      op_sub:    y = a_ext - b_ext;
      op_adc:    y = a_ext + b_ext + cin_ext;
      op_sbb:    y = a_ext - b_ext - cin_ext;
      default:   y = '0;
    endcase
  end

endmodule

`default_nettype wire

/* cpu16/cpu16_regfile.sv */
`default_nettype none

module cpu16_regfile (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [cpu16_pkg::reg_sel_width-1:0] rd_a_sel,
  input  logic [cpu16_pkg::reg_sel_width-1:0] rd_b_sel,
  output logic [cpu16_pkg::data_width-1:0]    rd_a,
  output logic [cpu16_pkg::data_width-1:0]    rd_b,
  input  logic                                wr_en,
  input  logic [cpu16_pkg::reg_sel_width-1:0] wr_sel,
  input  logic [cpu16_pkg::data_width-1:0]    wr_data,
  input  logic                                ip_load,
  input  logic [cpu16_pkg::data_width-1:0]    ip_value,
  input  logic                                sp_inc,
  input  logic                                sp_dec,
  output logic [cpu16_pkg::data_width-1:0]    ip,
  output logic [cpu16_pkg::data_width-1:0]    sp
);

  import cpu16_pkg::*;

  logic [data_width-1:0] regs [reg_count];

  assign rd_a = regs[rd_a_sel];  // combinational reads
  assign rd_b = regs[rd_b_sel];
  assign ip   = regs[ip_index];
  assign sp   = regs[sp_index];

  // later assignments win: general write > ip_load > sp strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      regs[ip_index] <= ip_reset_value;  // only ip has a defined start
    end else begin
      if (sp_inc)
        regs[sp_index] <= sp + 16'd1;
      else if (sp_dec)
        regs[sp_index] <= sp - 16'd1;

      if (ip_load)
        regs[ip_index] <= ip_value;

      if (wr_en)
        regs[wr_sel] <= wr_data;
    end
  end

  // the decoder never asks for a push and a pop at once
  sp_strobe_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(sp_inc && sp_dec)
  );

endmodule

`default_nettype wire

/* cpu16/cpu16_core.sv */
`default_nettype none

module cpu16_core (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             hold,
  output logic                             busy,
  output logic [cpu16_pkg::data_width-1:0] address,
  input  logic [cpu16_pkg::data_width-1:0] data_in,
  output logic [cpu16_pkg::data_width-1:0] data_out,
  output logic                             write,
  output logic                             carry_flag,
  output logic                             zero_flag,
  output logic                             neg_flag
);

  import cpu16_pkg::*;

  cpu_state_t state, state_next;
  logic       busy_next;
  logic       write_next;
  logic       jump_pending, jump_next;  // store-with-jump target still to load

  logic [data_width-1:0] address_next;
  logic [data_width-1:0] data_out_next;
  logic [data_width-1:0] opcode;        // held for compute and the jump
  alu_op_t               aluop, aluop_next;

  // register file hookup
  logic [reg_sel_width-1:0] rd_a_sel, rd_b_sel;
  logic [data_width-1:0]    rd_a, rd_b;
  logic                     wr_en;
  logic                     ip_load;
  logic [data_width-1:0]    ip_value;
  logic                     sp_inc, sp_dec;
  logic [data_width-1:0]    ip;

  logic [data_width-1:0] alu_b;
  logic [data_width:0]   y;

  logic [data_width-1:0] zp_addr;
  logic [data_width-1:0] index_addr;
  logic [data_width-1:0] branch_offset;
  logic [data_width-1:0] fetch_addr;
  logic                  src_is_sp;
  logic                  branch_taken;

  // decode reads rdest and rsrc from the incoming word, later from opcode
  assign rd_a_sel = (state == st_decode) ? data_in[10:8] : opcode[10:8];
  assign rd_b_sel = (state == st_decode) ? data_in[2:0]
                  : (state == st_select) ? opcode[5:3]  // jump target register
                  : opcode[2:0];

  // both read ports are taken in decode, so the jump lands at the next fetch
  assign fetch_addr = jump_pending ? rd_b : ip;

  assign zp_addr       = {8'h00, data_in[7:0]};
  assign index_addr    = rd_b + {{11{data_in[7]}}, data_in[7:3]};
  assign branch_offset = {{8{data_in[7]}}, data_in[7:0]};
  assign src_is_sp     = (data_in[2:0] == sp_index);

  // any selected flag matching the polarity bit
  assign branch_taken = (data_in[8]  && (data_in[11] == carry_flag)) ||
                        (data_in[9]  && (data_in[11] == zero_flag))  ||
                        (data_in[10] && (data_in[11] == neg_flag));

  // b operand: byte constant, bus word or rsrc
  assign alu_b = opcode[15] ? {8'h00, opcode[7:0]}
               : opcode[11] ? data_in
               : rd_b;

  cpu16_alu #(
    .width(data_width)
  ) u_alu (
    .a       (rd_a),
    .b       (alu_b),
    .carry_in(carry_flag),
    .op      (aluop),
    .y       (y)
  );

  cpu16_regfile u_regfile (
    .clk     (clk),
    .reset   (reset),
    .rd_a_sel(rd_a_sel),
    .rd_b_sel(rd_b_sel),
    .rd_a    (rd_a),
    .rd_b    (rd_b),
    .wr_en   (wr_en),
    .wr_sel  (opcode[10:8]),
    .wr_data (y[data_width-1:0]),
    .ip_load (ip_load),
    .ip_value(ip_value),
    .sp_inc  (sp_inc),
    .sp_dec  (sp_dec),
    .ip      (ip),
    .sp      ()
  );

  always_comb begin
    state_next    = state;
    busy_next     = busy;
    write_next    = 1'b0;      // single cycle strobe
    jump_next     = jump_pending;
    address_next  = address;
    data_out_next = data_out;
    aluop_next    = aluop;
    wr_en         = 1'b0;
    ip_load       = 1'b0;
    ip_value      = ip;
    sp_inc        = 1'b0;
    sp_dec        = 1'b0;

    case (state)
      st_reset: begin
        ip_load    = 1'b1;
        ip_value   = ip_reset_value;
        jump_next  = 1'b0;
        state_next = st_select;
      end
      st_select: begin
        if (hold) begin
          busy_next = 1'b1;       // stall only here
        end else begin
          busy_next    = 1'b0;
          address_next = fetch_addr;
          ip_load      = 1'b1;
          ip_value     = fetch_addr + 16'd1;
          jump_next    = 1'b0;
          state_next   = st_decode_wait;
        end
      end
      st_decode_wait: state_next = st_decode;
      st_decode: begin
        // bus operand needs one more cycle, byte immediates do not
        state_next = (data_in[11] && !data_in[15]) ? st_compute_wait : st_compute;
        casez (data_in)
          16'b00000???0???????: aluop_next = alu_op_t'(data_in[6:3]);  // reg op
          16'b00001???01??????: begin   // op with [rsrc]
            address_next = rd_b;
            aluop_next   = alu_op_t'(data_in[6:3]);
            sp_inc       = src_is_sp;
          end
          16'b00011???0????000,
          16'b01011????????000: begin   // op with word after instruction
            address_next = ip;
            ip_load      = 1'b1;
            ip_value     = ip + 16'd1;
            aluop_next   = alu_op_t'(data_in[6:3]);
          end
          16'b11??????????????: aluop_next = alu_op_t'(data_in[14:11]);  // byte imm
          16'b00101???????????: begin   // zero page load
            address_next = zp_addr;
            aluop_next   = op_load_b;
          end
          16'b00110???????????: begin   // zero page store
            address_next  = zp_addr;
            data_out_next = rd_a;
            write_next    = 1'b1;
            state_next    = st_select;
          end
          16'b01001???????????: begin   // indexed load, pops through sp
            address_next = index_addr;
            aluop_next   = op_load_b;
            sp_inc       = src_is_sp;
          end
          16'b01010???????????: begin   // indexed store, pushes through sp
            address_next  = index_addr;
            data_out_next = rd_a;
            write_next    = 1'b1;
            state_next    = st_select;
            sp_dec        = src_is_sp;
          end
          16'b01110???00??????: begin   // store then jump
            address_next  = rd_b;
            data_out_next = rd_a;
            write_next    = 1'b1;
            state_next    = st_select;
            sp_dec        = src_is_sp;
            jump_next     = 1'b1;
          end
          16'b1000????????????: begin   // relative branch
            if (branch_taken) begin
              ip_load  = 1'b1;
              ip_value = ip + branch_offset;
            end
            state_next = st_select;
          end
          default: state_next = st_reset;  // unknown opcode restarts
        endcase
      end
      st_compute_wait: state_next = st_compute;
      st_compute: begin
        wr_en      = 1'b1;
        state_next = st_select;
      end
      default: state_next = st_reset;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= st_reset;
      busy         <= 1'b1;
      write        <= 1'b0;
      jump_pending <= 1'b0;
      carry_flag   <= 1'b0;
      zero_flag    <= 1'b0;
      neg_flag     <= 1'b0;
    end else begin
      state        <= state_next;
      busy         <= busy_next;
      write        <= write_next;
      jump_pending <= jump_next;
      if (state == st_compute) begin
        if (aluop[2])
          carry_flag <= y[data_width];  // shifts and arithmetic only
        zero_flag <= ~|y[data_width-1:0];
        neg_flag  <= y[data_width-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    address  <= address_next;
    data_out <= data_out_next;
    aluop    <= aluop_next;
    if (state == st_decode)
      opcode <= data_in;
  end

  write_after_decode: assert property (
    @(posedge clk) disable iff (reset) write |-> $past(state) == st_decode
  );

  state_legal: assert property (
    @(posedge clk) disable iff (reset)
    state inside {st_reset, st_select, st_decode, st_compute, st_decode_wait, st_compute_wait}
  );

  // fetch address sits on the bus while decode_wait runs
  fetch_not_busy: assert property (
    @(posedge clk) disable iff (reset) (state == st_decode_wait) |-> !busy
  );

endmodule

`default_nettype wire

/* src/cpu16_memory.sv */
`default_nettype none

module cpu16_memory (
  input  logic                                 clk,
  input  logic [cpu16_pkg::data_width-1:0]     address,
  output logic [cpu16_pkg::data_width-1:0]     data_out,   // to the core
  input  logic [cpu16_pkg::data_width-1:0]     wr_data,
  input  logic                                 write,
  input  logic                                 load_en,
  input  logic [cpu16_pkg::rom_addr_width-1:0] load_addr,
  input  logic [cpu16_pkg::data_width-1:0]     load_data
);

  import cpu16_pkg::*;

  localparam int ram_depth = 2 ** rom_base_bit;  // whole low half

  logic [data_width-1:0] ram [ram_depth];
  logic [data_width-1:0] rom [rom_depth];

  logic                      is_rom;
  logic [rom_base_bit-1:0]   ram_index;
  logic [rom_addr_width-1:0] rom_index;

  assign is_rom    = address[rom_base_bit];
  assign ram_index = address[rom_base_bit-1:0];
  assign rom_index = address[rom_addr_width-1:0];  // rom mirrors in upper half

  // bus writes reach ram only
  always_ff @(posedge clk) begin
    if (write && !is_rom)
      ram[ram_index] <= wr_data;
  end

  // program load port, one word per cycle
  always_ff @(posedge clk) begin
    if (load_en)
      rom[load_addr] <= load_data;
  end

  // registered read, old data on a same-cycle write
  always_ff @(posedge clk) begin
    if (is_rom)
      data_out <= rom[rom_index];
    else
      data_out <= ram[ram_index];
  end

  // core stores never target program space
  no_rom_write: assert property (
    @(posedge clk) write |-> !is_rom
  );

endmodule

`default_nettype wire

/* src/cpu16_system.sv */
`default_nettype none

module cpu16_system (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 hold,
  input  logic                                 load_en,
  input  logic [cpu16_pkg::rom_addr_width-1:0] load_addr,
  input  logic [cpu16_pkg::data_width-1:0]     load_data,
  output logic                                 busy,
  output logic [cpu16_pkg::data_width-1:0]     bus_address,
  output logic                                 bus_write,
  output logic [cpu16_pkg::data_width-1:0]     bus_wdata,
  output logic                                 carry_flag,
  output logic                                 zero_flag,
  output logic                                 neg_flag
);

  import cpu16_pkg::*;

  logic [data_width-1:0] mem_rdata;  // word at last cycle's address

  cpu16_core u_core (
    .clk       (clk),
    .reset     (reset),
    .hold      (hold),
    .busy      (busy),
    .address   (bus_address),
    .data_in   (mem_rdata),
    .data_out  (bus_wdata),
    .write     (bus_write),
    .carry_flag(carry_flag),
    .zero_flag (zero_flag),
    .neg_flag  (neg_flag)
  );

  cpu16_memory u_memory (
    .clk      (clk),
    .address  (bus_address),
    .data_out (mem_rdata),
    .wr_data  (bus_wdata),
    .write    (bus_write),
    .load_en  (load_en),
    .load_addr(load_addr),
    .load_data(load_data)
  );

endmodule

`default_nettype wire

/* sim/cpu16_tb.sv */
`default_nettype none

module cpu16_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import cpu16_pkg::*;

  localparam logic [data_width-1:0] marker_addr = 16'h00ff;
  localparam int wait_limit = 3000;

  logic                      clk, reset, hold, load_en;
  logic [rom_addr_width-1:0] load_addr;
  logic [data_width-1:0]     load_data, bus_address, bus_wdata;
  logic                      busy, bus_write, carry_flag, zero_flag, neg_flag;

  logic [data_width-1:0] prog [rom_depth];
  int                    prog_len;
  logic [data_width-1:0] got_addr [$], got_data [$], exp_addr [$], exp_data [$];
  logic                  got_carry [$], exp_carry [$], exp_care [$];
  logic                  got_zero [$], got_neg [$];
  logic                  model_carry;
  integer                seed = 32'hdb9f_e8a4;

  cpu16_system dut (
    .clk(clk), .reset(reset), .hold(hold),
    .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
    .busy(busy), .bus_address(bus_address), .bus_write(bus_write), .bus_wdata(bus_wdata),
    .carry_flag(carry_flag), .zero_flag(zero_flag), .neg_flag(neg_flag)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // bus monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && bus_write) begin
      got_addr.push_back(bus_address);
      got_data.push_back(bus_wdata);
      got_carry.push_back(carry_flag);
      got_zero.push_back(zero_flag);
      got_neg.push_back(neg_flag);
    end
  end

  task automatic fail_and_stop();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [data_width-1:0] got, exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      fail_and_stop();
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      fail_and_stop();
    end
  endtask

  // reference alu rules, carry out in bit 16
  function automatic logic [data_width:0] alu_model(alu_op_t op, logic [15:0] a, b, logic cin);
    case (op)
      op_load_a: return {1'b0, a};
      op_inc:    return {1'b0, a} + 17'd1;
      op_dec:    return {1'b0, a} - 17'd1;
      op_asl:    return {a, 1'b0};
      op_lsr:    return {a[0], 1'b0, a[15:1]};
      op_rol:    return {a, cin};
      op_ror:    return {a[0], cin, a[15:1]};
      op_or:     return {1'b0, a | b};
      op_and:    return {1'b0, a & b};
      op_xor:    return {1'b0, a ^ b};
      op_load_b: return {1'b0, b};
      op_add:    return {1'b0, a} + {1'b0, b};
      op_sub:    return {1'b0, a} - {1'b0, b};
      op_adc:    return {1'b0, a} + {1'b0, b} + {16'd0, cin};
      op_sbb:    return {1'b0, a} - {1'b0, b} - {16'd0, cin};
      default:   return '0;
    endcase
  endfunction

  task automatic check_op_result(input alu_op_t op, input logic [15:0] a, b,
                                 input logic cin, input logic [15:0] got,
                                 input logic got_z, got_n);
    logic [data_width:0] exp;
    exp = alu_model(op, a, b, cin);
    check_word($sformatf("bus_wdata (%s)", op.name()), got, exp[15:0]);
    check_flag("zero_flag", got_z, exp[15:0] == 16'h0000);  // all low bits clear
    check_flag("neg_flag", got_n, exp[15]);
  endtask

  // instruction words
  function automatic logic [15:0] reg_op(alu_op_t op, logic [2:0] d, s);
    return {5'b00000, d, 1'b0, op, s};
  endfunction
  function automatic logic [15:0] mem_op(alu_op_t op, logic [2:0] d, s);
    return {5'b00001, d, 1'b0, op, s};  // op must be 8 or above
  endfunction
  function automatic logic [15:0] imm_op(alu_op_t op, logic [2:0] d, logic [7:0] k);
    return {1'b1, op, d, k};
  endfunction
  function automatic logic [15:0] zp_load(logic [2:0] d, logic [7:0] a);
    return {5'b00101, d, a};
  endfunction
  function automatic logic [15:0] zp_store(logic [2:0] d, logic [7:0] a);
    return {5'b00110, d, a};
  endfunction
  function automatic logic [15:0] index_load(logic [2:0] d, logic [4:0] off, logic [2:0] s);
    return {5'b01001, d, off, s};
  endfunction
  function automatic logic [15:0] index_store(logic [2:0] d, logic [4:0] off, logic [2:0] s);
    return {5'b01010, d, off, s};
  endfunction
  function automatic logic [15:0] branch_word(logic pol, logic [2:0] nzc, logic [7:0] off);
    return {4'b1000, pol, nzc, off};
  endfunction

  task automatic add_word(input logic [15:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic put_constant(input logic [2:0] d, input logic [15:0] value);
    add_word({5'b00011, d, 1'b0, 4'hb, 3'b000});  // load word after instruction
    add_word(value);
  endtask

  // marker store, then spin on the zero flag either way
  task automatic add_end();
    add_word(zp_store(3'd1, marker_addr[7:0]));
    add_word(branch_word(1'b0, 3'b010, 8'hff));
    add_word(branch_word(1'b1, 3'b010, 8'hfe));
  endtask

  task automatic expect_write(input logic [15:0] addr, data, input logic c, care);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_carry.push_back(c);
    exp_care.push_back(care);
  endtask

  task automatic random_word(output logic [15:0] w);
    logic [31:0] r;
    r = $random(seed);
    w = r[15:0];
  endtask

  // reg op plus a zero page store of its result, tracked by the model
  task automatic modeled_op(input alu_op_t op, input logic [2:0] d, s, input logic [15:0] a, b,
                            input logic [7:0] zp, output logic [15:0] res);
    logic [data_width:0] r;
    r = alu_model(op, a, b, model_carry);
    if (op[2])
      model_carry = r[16];
    res = r[15:0];
    add_word(reg_op(op, d, s));
    add_word(zp_store(d, zp));
    expect_write({8'h00, zp}, res, model_carry, 1'b1);
  endtask

  task automatic new_program();
    prog_len = 0;
    exp_addr.delete();
    exp_data.delete();
    exp_carry.delete();
    exp_care.delete();
  endtask

  task automatic load_and_reset();
    @(posedge clk);
    #1 reset = 1'b1;
    for (int i = 0; i < prog_len; i++) begin
      load_en   = 1'b1;
      load_addr = i[7:0];
      load_data = prog[i];
      @(posedge clk);
      #1;
    end
    load_en = 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_flag("busy", busy, 1'b1);
      check_flag("bus_write", bus_write, 1'b0);
    end
    got_addr.delete();
    got_data.delete();
    got_carry.delete();
    got_zero.delete();
    got_neg.delete();
    @(posedge clk);
    #1 reset = 1'b0;
  endtask

  task automatic hold_for(input int cycles);
    int n;
    hold = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 20) begin
        $display("Timeout: busy never rose while hold was high");
        fail_and_stop();
      end
    end while (!busy);
    repeat (cycles) begin
      @(negedge clk);
      check_flag("busy", busy, 1'b1);
      check_flag("bus_write", bus_write, 1'b0);
    end
    @(posedge clk);
    #1 hold = 1'b0;
  endtask

  task automatic run_program(input bit use_hold, input int hold_cycles);
    int  n;
    bit  held;
    load_and_reset();
    n = 0;
    held = 1'b0;
    while (!(got_addr.size() > 0 && got_addr[$] == marker_addr)) begin
      @(posedge clk);
      #1;
      n++;
      if (n > wait_limit) begin
        $display("Timeout: the program never stored to the marker address");
        fail_and_stop();
      end
      if (use_hold && !held && got_addr.size() >= 2) begin
        hold_for(hold_cycles);
        held = 1'b1;
      end
    end
  endtask

  task automatic compare_writes();
    if (got_addr.size() != exp_addr.size() + 1) begin
      $display("Wrong number of bus writes: %0d, expected %0d",
               got_addr.size(), exp_addr.size() + 1);
      fail_and_stop();
    end
    foreach (exp_addr[i]) begin
      check_word("bus_address", got_addr[i], exp_addr[i]);
      check_word("bus_wdata", got_data[i], exp_data[i]);
      if (exp_care[i])
        check_flag("carry_flag", got_carry[i], exp_carry[i]);
    end
  endtask

  task automatic check_reset();
    int n;
    new_program();
    add_end();
    load_and_reset();
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 10) begin
        $display("Timeout: no fetch after reset");
        fail_and_stop();
      end
      check_flag("bus_write", bus_write, 1'b0);
    end while (busy);
    check_word("bus_address", bus_address, ip_reset_value);
  endtask

  task automatic build_alu_program(input logic [7:0] a, b);
    alu_op_t reg_ops [7];
    alu_op_t imm_ops [4];
    reg_ops = '{op_or, op_and, op_xor, op_add, op_sub, op_inc, op_dec};
    imm_ops = '{op_xor, op_add, op_sub, op_and};
    new_program();
    add_word(imm_op(op_load_b, 3'd2, b));
    for (int i = 0; i < 7; i++) begin
      add_word(imm_op(op_load_b, 3'd3, a));
      add_word(reg_op(reg_ops[i], 3'd3, 3'd2));
      add_word(zp_store(3'd3, 8'h10 + i[7:0]));
    end
    for (int i = 0; i < 4; i++) begin
      add_word(imm_op(op_load_b, 3'd4, a));
      add_word(imm_op(imm_ops[i], 3'd4, b));
      add_word(zp_store(3'd4, 8'h18 + i[7:0]));
    end
    add_end();
  endtask

  task automatic check_alu_writes(input logic [7:0] a, b);
    alu_op_t reg_ops [7];
    alu_op_t imm_ops [4];
    reg_ops = '{op_or, op_and, op_xor, op_add, op_sub, op_inc, op_dec};
    imm_ops = '{op_xor, op_add, op_sub, op_and};
    if (got_addr.size() != 12) begin
      $display("Wrong number of bus writes: %0d, expected 12", got_addr.size());
      fail_and_stop();
    end
    for (int i = 0; i < 7; i++) begin
      check_word("bus_address", got_addr[i], 16'h0010 + {8'h00, i[7:0]});
      check_op_result(reg_ops[i], {8'h00, a}, {8'h00, b}, 1'b0, got_data[i],
                      got_zero[i], got_neg[i]);
    end
    for (int i = 0; i < 4; i++) begin
      check_word("bus_address", got_addr[i + 7], 16'h0018 + {8'h00, i[7:0]});
      check_op_result(imm_ops[i], {8'h00, a}, {8'h00, b}, 1'b0, got_data[i + 7],
                      got_zero[i + 7], got_neg[i + 7]);
    end
  endtask

  task automatic test_alu_ops();
    logic [15:0] a, b;
    random_word(a);
    random_word(b);
    build_alu_program(a[7:0], b[7:0]);
    run_program(1'b0, 0);
    check_alu_writes(a[7:0], b[7:0]);
  endtask

  task automatic test_carry_chain();
    logic [15:0] x, y, p, q, s, t, e1, e2, e3, e4, e5;
    random_word(x);
    random_word(y);
    random_word(p);
    random_word(q);
    random_word(s);
    random_word(t);
    x[15] = 1'b1;  // both top bits set, so the add overflows
    y[15] = 1'b1;
    new_program();
    model_carry = 1'b0;
    put_constant(3'd1, x);
    put_constant(3'd2, y);
    modeled_op(op_add, 3'd1, 3'd2, x, y, 8'h40, e1);
    put_constant(3'd3, p);
    put_constant(3'd4, q);
    modeled_op(op_adc, 3'd3, 3'd4, p, q, 8'h41, e2);
    put_constant(3'd5, s);
    put_constant(3'd4, t);
    modeled_op(op_sub, 3'd5, 3'd4, s, t, 8'h42, e3);
    modeled_op(op_sbb, 3'd3, 3'd4, e2, t, 8'h43, e4);
    modeled_op(op_rol, 3'd1, 3'd1, e1, e1, 8'h44, e5);
    modeled_op(op_ror, 3'd2, 3'd2, y, y, 8'h45, e5);
    modeled_op(op_or, 3'd5, 3'd4, e3, t, 8'h46, e5);  // carry must survive
    add_end();
    run_program(1'b0, 0);
    compare_writes();
    check_flag("carry_flag", carry_flag, model_carry);
  endtask

  task automatic test_memory_forms();
    logic [15:0] v, w;
    random_word(v);
    random_word(w);
    new_program();
    put_constant(sp_index, 16'h0100);
    put_constant(3'd1, v);
    add_word(index_store(3'd1, 5'd0, sp_index));  // push, sp drops to 00ff
    expect_write(16'h0100, v, 1'b0, 1'b0);
    add_word(zp_store(sp_index, 8'h20));
    expect_write(16'h0020, 16'h00ff, 1'b0, 1'b0);
    add_word(index_load(3'd2, 5'd1, sp_index));   // pop from sp+1
    add_word(zp_store(3'd2, 8'h21));
    expect_write(16'h0021, v, 1'b0, 1'b0);
    add_word(zp_store(sp_index, 8'h22));
    expect_write(16'h0022, 16'h0100, 1'b0, 1'b0);
    add_word(zp_load(3'd3, 8'h21));
    add_word(zp_store(3'd3, 8'h23));
    expect_write(16'h0023, v, 1'b0, 1'b0);
    put_constant(3'd4, w);
    put_constant(3'd5, 16'h0021);
    add_word(mem_op(op_add, 3'd4, 3'd5));
    add_word(zp_store(3'd4, 8'h24));
    expect_write(16'h0024, w + v, 1'b0, 1'b0);
    add_end();
    run_program(1'b0, 0);
    compare_writes();
  endtask

  task automatic test_branch_and_jump();
    logic [15:0] r;
    logic [7:0]  count;
    random_word(r);
    count = 8'd3 + {6'd0, r[1:0]};
    new_program();
    add_word(imm_op(op_load_b, 3'd1, count));
    add_word(zp_store(3'd1, 8'h30));               // loop top
    add_word(reg_op(op_dec, 3'd1, 3'd1));
    add_word(branch_word(1'b0, 3'b010, 8'hfd));    // back two words while not zero
    for (int k = count; k >= 1; k--)
      expect_write(16'h0030, {8'h00, k[7:0]}, 1'b0, 1'b0);
    // two constants, the jump and a skipped store come before the target
    put_constant(3'd2, ip_reset_value + prog_len[15:0] + 16'd6);
    put_constant(3'd3, 16'h0040);
    add_word({5'b01110, 3'd1, 2'b00, 3'd2, 3'd3});
    expect_write(16'h0040, 16'h0000, 1'b0, 1'b0);
    add_word(zp_store(3'd1, 8'h50));
    add_end();
    run_program(1'b0, 0);
    compare_writes();
  endtask

  task automatic test_hold();
    logic [15:0]           a, b, r;
    logic [data_width-1:0] ref_data [$];
    random_word(a);
    random_word(b);
    random_word(r);
    build_alu_program(a[7:0], b[7:0]);
    run_program(1'b0, 0);
    ref_data = got_data;
    run_program(1'b1, 4 + int'(r[3:0]));
    check_alu_writes(a[7:0], b[7:0]);
    foreach (ref_data[i])
      check_word("bus_wdata", got_data[i], ref_data[i]);
  endtask

  initial begin
    reset     = 1'b1;
    hold      = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    check_reset();
    test_alu_ops();
    test_carry_chain();
    test_memory_forms();
    test_branch_and_jump();
    test_hold();
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* cpu16.f */
common/cpu16_pkg.sv
cpu16/cpu16_alu.sv
cpu16/cpu16_regfile.sv
cpu16/cpu16_core.sv
src/cpu16_memory.sv
src/cpu16_system.sv
sim/cpu16_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the cpu16 testbench with Verilator, run it and look for the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f cpu16.f --top-module cpu16_tb -Mdir obj_dir -o cpu16_sim

if ! output=$(./obj_dir/cpu16_sim 2>&1); then
  echo "$output"
  exit 1
fi
echo "$output"

if grep -q "All tests passed" <<< "$output"; then
  exit 0
else
  exit 1
fi
